//--- verilog/afifo_pkg.sv
// Shared constants and helpers for the dual-clock FIFO
// Default geometry, synchronizer depth and Gray code conversion

package afifo_pkg;

	////////////////////////////////////////////////////////////
	// Default sizes
	////////////////////////////////////////////////////////////

	// Log two of the FIFO depth
	localparam int DEF_LGFIFO = 3;

	// Data word width in bits
	localparam int DEF_WIDTH = 16;

	// Flops per clock crossing, two at the least
	localparam int DEF_NFF = 2;

	// Widest pointer the Gray helper accepts
	localparam int MAX_PTR_W = 16;

	////////////////////////////////////////////////////////////
	// Gray code conversion
	////////////////////////////////////////////////////////////

	// Binary to reflected Gray code
	// Adjacent values differ in one bit only, so a pointer sampled
	// mid-change in the other domain is off by at most one step
	// Callers keep only the low bits they need
	function automatic logic [MAX_PTR_W-1:0] bin_to_gray(
		input logic [MAX_PTR_W-1:0] bin
	);
		return bin ^ (bin >> 1);
	endfunction

endpackage

//--- verilog/afifo_gray_sync.sv
// Gray pointer synchronizer
// Carries one Gray coded pointer into a destination clock domain
// through a chain of NFF flops, cleared by the destination reset

`timescale 1ns/1ns

module afifo_gray_sync
	import afifo_pkg::*;
#(
	parameter int NFF   = DEF_NFF,
	parameter int PTR_W = DEF_LGFIFO + 1
)
(
	input  logic             i_clk,
	input  logic             i_reset_n,
	input  logic [PTR_W-1:0] i_gray,
	output logic [PTR_W-1:0] o_gray
);

	// Flop chain, first stage may go metastable
	(* ASYNC_REG = "TRUE" *) logic [PTR_W-1:0] sync_q [NFF];

	// Shift the pointer one stage per destination edge
	always_ff @(posedge i_clk or negedge i_reset_n)
	begin
		if (!i_reset_n)
		begin
			for (int i = 0; i < NFF; i++)
				sync_q[i] <= '0;
		end
		else
		begin
			sync_q[0] <= i_gray;
			for (int i = 1; i < NFF; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	// Last stage is settled
	assign o_gray = sync_q[NFF-1];

endmodule

//--- verilog/afifo_wr_ctrl.sv
// Write side controller of the dual-clock FIFO
// Keeps the binary and Gray write pointers in the write clock
// domain and derives the full flag from the synchronized read pointer

`timescale 1ns/1ns

module afifo_wr_ctrl
	import afifo_pkg::*;
#(
	parameter int LGFIFO = DEF_LGFIFO
)
(
	input  logic              i_wclk,
	input  logic              i_wr_reset_n,
	input  logic              i_wr,
	input  logic [LGFIFO:0]   i_rgray_sync,
	output logic              o_wr_full,
	output logic              o_wr_en,
	output logic [LGFIFO-1:0] o_wr_addr,
	output logic [LGFIFO:0]   o_wgray
);

	// Binary write pointer, one extra bit for wrap detection
	logic [LGFIFO:0]      wr_bin;
	logic [LGFIFO:0]      wr_bin_next;
	logic [MAX_PTR_W-1:0] wr_gray_wide;

	////////////////////////////////////////////////////////////
	// Pointer update
	////////////////////////////////////////////////////////////

	assign wr_bin_next  = wr_bin + 1'b1;
	assign wr_gray_wide = bin_to_gray(MAX_PTR_W'(wr_bin_next));

	// Accepted write only when not full
	assign o_wr_en = i_wr && !o_wr_full;

	// Both copies advance together on an accepted write
	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wr_bin  <= '0;
			o_wgray <= '0;
		end
		else if (o_wr_en)
		begin
			wr_bin  <= wr_bin_next;
			o_wgray <= wr_gray_wide[LGFIFO:0];
		end
	end

	// Memory slot, the wrap bit is dropped
	assign o_wr_addr = wr_bin[LGFIFO-1:0];

	////////////////////////////////////////////////////////////
	// Full flag
	////////////////////////////////////////////////////////////

	// Full when the reader is one whole lap behind
	// In Gray code that means the top two bits differ and the rest match
	assign o_wr_full = (i_rgray_sync ==
		{~o_wgray[LGFIFO:LGFIFO-1], o_wgray[LGFIFO-2:0]});

endmodule

//--- verilog/afifo_rd_ctrl.sv
// Read side controller of the dual-clock FIFO
// Keeps the binary and Gray read pointers in the gbl_clk domain,
// tracks memory empty against the synchronized write pointer and
// drives the load of the registered read output

`timescale 1ns/1ns

module afifo_rd_ctrl
	import afifo_pkg::*;
#(
	parameter int LGFIFO = DEF_LGFIFO
)
(
	input  logic              gbl_clk,
	input  logic              i_rd_reset_n,
	input  logic              i_rd,
	input  logic [LGFIFO:0]   i_wgray_sync,
	output logic              o_rd_empty,
	output logic              o_rd_load,
	output logic [LGFIFO-1:0] o_rd_addr,
	output logic [LGFIFO:0]   o_rgray
);

	// Binary read pointer, one extra bit for wrap detection
	logic [LGFIFO:0]      rd_bin;
	logic [LGFIFO:0]      rd_bin_next;
	logic [MAX_PTR_W-1:0] rd_gray_wide;

	// No word left in memory, output register excluded
	logic                 mem_empty;

	////////////////////////////////////////////////////////////
	// Memory empty and load control
	////////////////////////////////////////////////////////////

	// Pointers equal including the lap bit
	assign mem_empty = (i_wgray_sync == o_rgray);

	// Refill the output register when it is vacant or being consumed
	assign o_rd_load = o_rd_empty || i_rd;

	////////////////////////////////////////////////////////////
	// Pointer update
	////////////////////////////////////////////////////////////

	assign rd_bin_next  = rd_bin + 1'b1;
	assign rd_gray_wide = bin_to_gray(MAX_PTR_W'(rd_bin_next));

	// A word leaves memory on a load with data present
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rd_bin  <= '0;
			o_rgray <= '0;
		end
		else if (o_rd_load && !mem_empty)
		begin
			rd_bin  <= rd_bin_next;
			o_rgray <= rd_gray_wide[LGFIFO:0];
		end
	end

	// Head slot, the wrap bit is dropped
	assign o_rd_addr = rd_bin[LGFIFO-1:0];

	////////////////////////////////////////////////////////////
	// Output empty flag
	////////////////////////////////////////////////////////////

	// Follows the output register
	// Set when a load finds memory empty, cleared when one fills it
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			o_rd_empty <= 1'b1;
		else if (o_rd_load)
			o_rd_empty <= mem_empty;
	end

endmodule

//--- verilog/afifo_mem.sv
// Storage array of the dual-clock FIFO
// Write port on the write clock, registered read port on gbl_clk
// that refreshes only when the read controller loads

`timescale 1ns/1ns

module afifo_mem
	import afifo_pkg::*;
#(
	parameter int LGFIFO = DEF_LGFIFO,
	parameter int WIDTH  = DEF_WIDTH
)
(
	input  logic              i_wclk,
	input  logic              i_wr_en,
	input  logic [LGFIFO-1:0] i_wr_addr,
	input  logic [WIDTH-1:0]  i_wr_data,
	input  logic              gbl_clk,
	input  logic              i_rd_load,
	input  logic [LGFIFO-1:0] i_rd_addr,
	output logic [WIDTH-1:0]  o_rd_data
);

	// 2^LGFIFO words
	logic [WIDTH-1:0] mem [1<<LGFIFO];

	// Write port, enable already qualified with not full
	always_ff @(posedge i_wclk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// Output register holds the head word until the next load
	always_ff @(posedge gbl_clk)
	begin
		if (i_rd_load)
			o_rd_data <= mem[i_rd_addr];
	end

endmodule

//--- verilog/afifo_top.sv
// Dual-clock FIFO top level
// A writer on i_wclk pushes words through a small memory to a
// reader on gbl_clk; each side has its own controller and flag,
// and the Gray pointers cross through two synchronizers

`timescale 1ns/1ns

module afifo_top
	import afifo_pkg::*;
#(
	parameter int LGFIFO = DEF_LGFIFO,
	parameter int WIDTH  = DEF_WIDTH,
	parameter int NFF    = DEF_NFF
)
(
	// Write side
	input  logic             i_wclk,
	input  logic             i_wr_reset_n,
	input  logic             i_wr,
	input  logic [WIDTH-1:0] i_wr_data,
	output logic             o_wr_full,

	// Read side
	input  logic             gbl_clk,
	input  logic             i_rd_reset_n,
	input  logic             i_rd,
	output logic [WIDTH-1:0] o_rd_data,
	output logic             o_rd_empty
);

	////////////////////////////////////////////////////////////
	// Internal wires
	////////////////////////////////////////////////////////////

	// Write domain
	logic              wr_en;
	logic [LGFIFO-1:0] wr_addr;
	logic [LGFIFO:0]   wgray;
	logic [LGFIFO:0]   rgray_sync;

	// Read domain
	logic              rd_load;
	logic [LGFIFO-1:0] rd_addr;
	logic [LGFIFO:0]   rgray;
	logic [LGFIFO:0]   wgray_sync;

	////////////////////////////////////////////////////////////
	// Controllers
	////////////////////////////////////////////////////////////

	afifo_wr_ctrl #(
		.LGFIFO (LGFIFO)
	) u_wr_ctrl (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_rgray_sync (rgray_sync),
		.o_wr_full    (o_wr_full),
		.o_wr_en      (wr_en),
		.o_wr_addr    (wr_addr),
		.o_wgray      (wgray)
	);

	afifo_rd_ctrl #(
		.LGFIFO (LGFIFO)
	) u_rd_ctrl (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.i_wgray_sync (wgray_sync),
		.o_rd_empty   (o_rd_empty),
		.o_rd_load    (rd_load),
		.o_rd_addr    (rd_addr),
		.o_rgray      (rgray)
	);

	////////////////////////////////////////////////////////////
	// Clock domain crossings
	////////////////////////////////////////////////////////////

	// Read pointer into the write domain, for the full flag
	afifo_gray_sync #(
		.NFF   (NFF),
		.PTR_W (LGFIFO + 1)
	) u_rgray_to_wr (
		.i_clk     (i_wclk),
		.i_reset_n (i_wr_reset_n),
		.i_gray    (rgray),
		.o_gray    (rgray_sync)
	);

	// Write pointer into the read domain, for empty tracking
	afifo_gray_sync #(
		.NFF   (NFF),
		.PTR_W (LGFIFO + 1)
	) u_wgray_to_rd (
		.i_clk     (gbl_clk),
		.i_reset_n (i_rd_reset_n),
		.i_gray    (wgray),
		.o_gray    (wgray_sync)
	);

	// Storage with registered read port
	afifo_mem #(
		.LGFIFO (LGFIFO),
		.WIDTH  (WIDTH)
	) u_mem (
		.i_wclk    (i_wclk),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (i_wr_data),
		.gbl_clk   (gbl_clk),
		.i_rd_load (rd_load),
		.i_rd_addr (rd_addr),
		.o_rd_data (o_rd_data)
	);

endmodule

//--- verif/afifo_props.sv
// Bound assertions for the dual-clock FIFO
// Hold of the head word, empty flag after reset and the cause
// of every rise of the full flag

`timescale 1ns/1ns

module afifo_props
	import afifo_pkg::*;
#(
	parameter int WIDTH = DEF_WIDTH
)
(
	input logic             gbl_clk,
	input logic             i_rd_reset_n,
	input logic             i_rd,
	input logic             o_rd_empty,
	input logic [WIDTH-1:0] o_rd_data,
	input logic             i_wclk,
	input logic             i_wr_reset_n,
	input logic             i_wr,
	input logic             o_wr_full
);

	// Failed assertions so far
	int fail_count = 0;

	// Head word holds while the reader stalls
	a_rd_hold: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(!o_rd_empty && !i_rd) |=> $stable(o_rd_data))
	else
	begin
		fail_count++;
		$error("o_rd_data changed while the reader held it");
	end

	// Nothing to read right after reset
	a_empty_after_reset: assert property (@(posedge gbl_clk)
		$rose(i_rd_reset_n) |=> o_rd_empty)
	else
	begin
		fail_count++;
		$error("o_rd_empty low in the cycle after reset release");
	end

	// Only an accepted write can fill the FIFO
	a_full_cause: assert property (@(posedge i_wclk) disable iff (!i_wr_reset_n)
		$rose(o_wr_full) |-> $past(i_wr && !o_wr_full))
	else
	begin
		fail_count++;
		$error("o_wr_full rose without an accepted write");
	end

endmodule

bind afifo_top afifo_props #(.WIDTH(WIDTH)) props_inst (.*);

//--- verif/afifo_tb.sv
// Directed testbench for the dual-clock FIFO
// Drives the writer on i_wclk and the reader on gbl_clk and checks
// every word that leaves against a queue model of the contents

`timescale 1ns/1ns

module afifo_tb
	import afifo_pkg::*;
();

	localparam int LGFIFO       = DEF_LGFIFO;
	localparam int WIDTH        = DEF_WIDTH;
	localparam int NFF          = DEF_NFF;
	localparam int DEPTH        = 1 << LGFIFO;
	// Memory slots plus the output register
	localparam int CAPACITY     = DEPTH + 1;
	localparam int GCLK_HALF    = 4;
	localparam int WCLK_HALF    = 7;
	localparam int FILL_TRIES   = DEPTH + 6;
	localparam int DROP_TRIES   = 3;
	localparam int EMPTY_PULSES = 4;
	localparam int STREAM_WORDS = 64;
	// gbl_clk cycles a written word may take to show up
	localparam int RD_WAIT_LIMIT = 8 * (NFF + 2);
	// Write cycles full may stay high once a slot is really free
	localparam int STALE_LIMIT  = NFF + 3;
	localparam int TOTAL_WORDS  = 1 + DEPTH + FILL_TRIES + DROP_TRIES + CAPACITY
		+ EMPTY_PULSES + STREAM_WORDS;
	localparam int WATCHDOG_NS  = TOTAL_WORDS * 40 * (2 * WCLK_HALF) + 16 * 2 * GCLK_HALF;

	logic             gbl_clk = 1'b0;
	logic             i_wclk  = 1'b0;
	logic             i_rd_reset_n;
	logic             i_wr_reset_n;
	logic             i_wr;
	logic [WIDTH-1:0] i_wr_data;
	logic             i_rd;
	logic             o_wr_full;
	logic             o_rd_empty;
	logic [WIDTH-1:0] o_rd_data;

	// Model state
	logic [WIDTH-1:0] model [$];
	logic [15:0]      lfsr_q = 16'd74;
	string            cur_test;
	int               full_stale = 0;

	afifo_top #(
		.LGFIFO (LGFIFO),
		.WIDTH  (WIDTH),
		.NFF    (NFF)
	) afifo_top_inst (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.o_wr_full    (o_wr_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty)
	);

	// Unrelated periods so the crossing sees every phase
	always #GCLK_HALF gbl_clk = ~gbl_clk;
	always #WCLK_HALF i_wclk = ~i_wclk;

	////////////////////////////////////////////////////////////
	// Random bits and checks
	////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic next_rand_bit();
		logic fb;
		fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic logic [WIDTH-1:0] rand_word();
		logic [WIDTH-1:0] w;
		for (int i = 0; i < WIDTH; i++)
			w[i] = next_rand_bit();
		return w;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic compare_data(input string name, input logic [WIDTH-1:0] expected,
		input logic [WIDTH-1:0] actual);
		if (actual !== expected)
			fail_now($sformatf("Error in %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic compare_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			fail_now($sformatf("Error in %s: expected %b, actual %b", name, expected, actual));
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		if (actual != expected)
			fail_now($sformatf("Error in %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	////////////////////////////////////////////////////////////
	// Writer and reader drivers
	////////////////////////////////////////////////////////////

	// One write attempt
	// Full only moves on i_wclk so the falling edge shows the value
	// the next rising edge uses
	task automatic write_once(input logic [WIDTH-1:0] data, output logic accepted);
		@(posedge i_wclk);
		i_wr      <= 1'b1;
		i_wr_data <= data;
		@(negedge i_wclk);
		accepted = !o_wr_full;
		if (accepted)
			model.push_back(data);
		// Full with free room must clear once the read pointer crosses
		if (o_wr_full && model.size() < DEPTH)
			full_stale++;
		else
			full_stale = 0;
		if (full_stale > STALE_LIMIT)
			compare_flag({cur_test, " full release"}, 1'b0, o_wr_full);
	endtask

	task automatic push_word(input logic [WIDTH-1:0] data);
		logic accepted;
		accepted = 1'b0;
		while (!accepted)
			write_once(data, accepted);
	endtask

	task automatic write_idle();
		@(posedge i_wclk);
		i_wr <= 1'b0;
	endtask

	task automatic wait_not_empty(input string name);
		int waited;
		waited = 0;
		@(negedge gbl_clk);
		while (o_rd_empty)
		begin
			waited++;
			if (waited > RD_WAIT_LIMIT)
				fail_now({name, ": o_rd_empty stayed high, no word reached the reader"});
			@(negedge gbl_clk);
		end
	endtask

	// Check the head word and consume it with a one cycle strobe
	task automatic pop_word(input string name);
		wait_not_empty(name);
		if (model.size() == 0)
			fail_now({name, ": a word came out that was never written"});
		compare_data(name, model[0], o_rd_data);
		void'(model.pop_front());
		@(posedge gbl_clk);
		i_rd <= 1'b1;
		@(posedge gbl_clk);
		i_rd <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic single_word();
		cur_test = "single_word";
		push_word(rand_word());
		write_idle();
		pop_word(cur_test);
		// The consuming edge finds memory empty
		@(negedge gbl_clk);
		compare_flag(cur_test, 1'b1, o_rd_empty);
	endtask

	task automatic burst_order();
		cur_test = "burst_order";
		for (int i = 0; i < DEPTH; i++)
			push_word(rand_word());
		write_idle();
		for (int i = 0; i < DEPTH; i++)
			pop_word(cur_test);
	endtask

	task automatic fill_full();
		logic accepted;
		int   n_accepted;
		cur_test = "fill_full";
		n_accepted = 0;
		for (int i = 0; i < FILL_TRIES; i++)
		begin
			write_once(rand_word(), accepted);
			if (accepted)
				n_accepted++;
		end
		write_idle();
		repeat (NFF + 2) @(posedge i_wclk);
		@(negedge i_wclk);
		compare_flag(cur_test, 1'b1, o_wr_full);
		compare_count(cur_test, CAPACITY, n_accepted);
		// Writes while full are dropped
		n_accepted = 0;
		for (int i = 0; i < DROP_TRIES; i++)
		begin
			write_once(rand_word(), accepted);
			if (accepted)
				n_accepted++;
		end
		write_idle();
		compare_count({cur_test, " dropped"}, 0, n_accepted);
		for (int i = 0; i < CAPACITY; i++)
			pop_word(cur_test);
		repeat (RD_WAIT_LIMIT) @(posedge gbl_clk);
		@(negedge gbl_clk);
		compare_flag(cur_test, 1'b1, o_rd_empty);
		@(negedge i_wclk);
		compare_flag(cur_test, 1'b0, o_wr_full);
	endtask

	task automatic empty_read();
		logic [WIDTH-1:0] held;
		cur_test = "empty_read";
		repeat (4) @(posedge gbl_clk);
		@(negedge gbl_clk);
		compare_flag(cur_test, 1'b1, o_rd_empty);
		held = o_rd_data;
		for (int i = 0; i < EMPTY_PULSES; i++)
		begin
			@(posedge gbl_clk);
			i_rd <= 1'b1;
			@(posedge gbl_clk);
			i_rd <= 1'b0;
		end
		@(negedge gbl_clk);
		compare_flag(cur_test, 1'b1, o_rd_empty);
		compare_data(cur_test, held, o_rd_data);
	endtask

	task automatic stream_backpressure();
		logic [WIDTH-1:0] words [STREAM_WORDS];
		int               n_read;
		cur_test = "stream_backpressure";
		// Data drawn up front so the reader owns the LFSR during the run
		for (int i = 0; i < STREAM_WORDS; i++)
			words[i] = rand_word();
		n_read = 0;
		fork
			begin
				for (int i = 0; i < STREAM_WORDS; i++)
					push_word(words[i]);
				write_idle();
			end
			begin
				while (n_read < STREAM_WORDS)
				begin
					@(posedge gbl_clk);
					i_rd <= next_rand_bit();
					@(negedge gbl_clk);
					// Strobe and head word both hold up to the next edge
					if (i_rd && !o_rd_empty)
					begin
						if (model.size() == 0)
							fail_now({cur_test, ": a word came out that was never written"});
						compare_data(cur_test, model[0], o_rd_data);
						void'(model.pop_front());
						n_read++;
					end
				end
				@(posedge gbl_clk);
				i_rd <= 1'b0;
			end
		join
		@(negedge gbl_clk);
		compare_flag(cur_test, 1'b1, o_rd_empty);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		#(WATCHDOG_NS);
		fail_now("Watchdog expired, the run hung and did not finish");
	end

	// Stop at the first failure of a bound assertion
	initial
	begin
		wait (afifo_top_inst.props_inst.fail_count != 0);
		fail_now({cur_test, ": a bound assertion failed, see the error above"});
	end

	initial
	begin
		i_rd_reset_n = 1'b0;
		i_wr_reset_n = 1'b0;
		i_wr         = 1'b0;
		i_wr_data    = '0;
		i_rd         = 1'b0;
		cur_test     = "reset";
		repeat (16) @(posedge gbl_clk);
		i_rd_reset_n <= 1'b1;
		@(posedge i_wclk);
		i_wr_reset_n <= 1'b1;
		repeat (4) @(posedge gbl_clk);
		single_word();
		burst_order();
		fill_full();
		empty_read();
		stream_backpressure();
		repeat (4) @(posedge gbl_clk);
		if (model.size() == 0 && afifo_top_inst.props_inst.fail_count == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			fail_now("Run ended with assertion failures or words left unread");
	end

endmodule

//--- afifo.f
verilog/afifo_pkg.sv
verilog/afifo_gray_sync.sv
verilog/afifo_wr_ctrl.sv
verilog/afifo_rd_ctrl.sv
verilog/afifo_mem.sv
verilog/afifo_top.sv
verif/afifo_props.sv
verif/afifo_tb.sv

//--- Bender.yml
package:
  name: afifo

sources:
  # RTL, package first
  - verilog/afifo_pkg.sv
  - verilog/afifo_gray_sync.sv
  - verilog/afifo_wr_ctrl.sv
  - verilog/afifo_rd_ctrl.sv
  - verilog/afifo_mem.sv
  - verilog/afifo_top.sv

  # Verification
  - target: simulation
    files:
      - verif/afifo_props.sv
      - verif/afifo_tb.sv
